/* cu_buffer_pkg.sv */
// Shared widths, command codes and payload structs; imported by the RTL and the testbench
package cu_buffer_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  // Byte address into memory
  localparam int ADDR_W = 32;
  // One memory word per beat
  localparam int DATA_W = 32;
  // One strobe bit per data byte
  localparam int STRB_W = DATA_W / 8;
  // Requester tag, returned untouched with the response
  localparam int TAG_W  = 8;

  // ----------------------------------------------------------------------
  // Command codes
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    CMD_MEM_READ  = 2'd0,
    CMD_MEM_WRITE = 2'd1
  } cmd_e;

  // ----------------------------------------------------------------------
  // Requester side
  // ----------------------------------------------------------------------
  // Request FIFO word, 78 bits
  typedef struct packed {
    cmd_e              cmd;
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } cache_req_payload_t;

  // Valid is a one-cycle push strobe
  typedef struct packed {
    logic               valid;
    cache_req_payload_t payload;
  } cache_request_t;

  // Response FIFO word, 42 bits
  // Rdata holds read data, or the write data echoed back for writes
  typedef struct packed {
    cmd_e              cmd;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] rdata;
  } cache_resp_payload_t;

  // Valid is a level, held until consumed
  typedef struct packed {
    logic                valid;
    cache_resp_payload_t payload;
  } cache_response_t;

  // ----------------------------------------------------------------------
  // Memory side
  // ----------------------------------------------------------------------
  // Outbound single-beat access, valid is a strobe
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } mem_req_t;

  // Completion strobe, rdata only meaningful for reads
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

/* sync_fifo.sv */
// Synchronous first-word-fall-through FIFO with programmable-full; used for both queues
module sync_fifo #(
  parameter int WIDTH       = 32,
  parameter int DEPTH       = 32,
  parameter int PROG_THRESH = 16
) (
  input  logic             ap_clk,
  input  logic             areset_m_axi,
  input  logic [WIDTH-1:0] din,
  input  logic             wr_en,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             valid,
  output logic             full,
  output logic             empty,
  output logic             prog_full
);

  // ----------------------------------------------------------------------
  // Storage and pointers
  // ----------------------------------------------------------------------
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Occupancy, 0 to DEPTH
  logic [CNT_W-1:0] count;

  // Write port
  always_ff @(posedge ap_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointer update, wrap works for any depth
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy count
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Head and status
  // ----------------------------------------------------------------------
  // Head shows straight from the array
  assign dout      = mem[rd_ptr];
  assign empty     = (count == '0);
  assign valid     = ~empty;
  assign full      = (count == CNT_W'(DEPTH));
  // Leaves headroom below full for pushes already in flight
  assign prog_full = (count >= CNT_W'(PROG_THRESH));

  // Producers must respect full
  a_no_push_full: assert property (
    @(posedge ap_clk) disable iff (areset_m_axi) wr_en |-> !full
  ) else $error("sync_fifo: push while full");

  // Consumers must only pop a valid head
  a_no_pop_empty: assert property (
    @(posedge ap_clk) disable iff (areset_m_axi) rd_en |-> !empty
  ) else $error("sync_fifo: pop while empty");

endmodule

/* mem_cmd_engine.sv */
// Command FSM: pops one request, issues it on the memory port, pushes its response
module mem_cmd_engine
  import cu_buffer_pkg::*;
(
  input  logic                ap_clk,
  input  logic                areset_m_axi,
  input  cache_req_payload_t  req_head,
  input  logic                req_head_valid,
  output logic                req_pop,
  output logic                resp_push,
  output cache_resp_payload_t resp_din,
  input  logic                resp_prog_full,
  output mem_req_t            mem_req,
  input  logic                mem_ready,
  input  mem_rsp_t            mem_rsp,
  output logic                idle
);

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    STATE_RESET,
    STATE_READY,
    STATE_ISSUE,
    STATE_PEND
  } engine_state_e;

  engine_state_e      state;
  engine_state_e      next_state;
  // Request held while its memory access is outstanding
  cache_req_payload_t req_q;
  logic               head_is_write;
  logic               issue_fire;
  logic               rsp_fire;
  // Outstanding access tracker, independent of the FSM
  logic               mem_busy;

  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      state <= STATE_RESET;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      STATE_RESET: begin
        next_state = STATE_READY;
      end
      STATE_READY: begin
        // Hold here on memory or response back-pressure
        if (req_head_valid && !resp_prog_full && mem_ready) begin
          next_state = STATE_ISSUE;
        end
      end
      STATE_ISSUE: begin
        if (mem_ready) begin
          next_state = STATE_PEND;
        end
      end
      STATE_PEND: begin
        // Single access in flight, wait for its completion
        if (mem_rsp.valid) begin
          next_state = STATE_READY;
        end
      end
      default: begin
        next_state = STATE_RESET;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // Memory strobe and request pop
  // ----------------------------------------------------------------------
  assign head_is_write = (req_head.cmd == CMD_MEM_WRITE);
  assign issue_fire    = (state == STATE_ISSUE) && mem_ready;
  // Head leaves the FIFO on the same edge the access goes out
  assign req_pop       = issue_fire;

  always_comb begin
    mem_req.valid = issue_fire;
    mem_req.write = head_is_write;
    mem_req.addr  = req_head.addr;
    mem_req.wdata = req_head.wdata;
    // Reads never carry byte enables
    mem_req.wstrb = req_head.wstrb & {STRB_W{head_is_write}};
  end

  always_ff @(posedge ap_clk) begin
    if (issue_fire) begin
      req_q <= req_head;
    end
  end

  // ----------------------------------------------------------------------
  // Response build and push
  // ----------------------------------------------------------------------
  assign rsp_fire = (state == STATE_PEND) && mem_rsp.valid;

  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      resp_push <= 1'b0;
    end else begin
      resp_push <= rsp_fire;
    end
  end

  // Writes echo their own data, reads return memory data
  always_ff @(posedge ap_clk) begin
    if (rsp_fire) begin
      resp_din.cmd   <= req_q.cmd;
      resp_din.tag   <= req_q.tag;
      resp_din.rdata <= (req_q.cmd == CMD_MEM_WRITE) ? req_q.wdata : mem_rsp.rdata;
    end
  end

  // Not idle while the last response is still being pushed
  assign idle = (state == STATE_READY) && !resp_push;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      mem_busy <= 1'b0;
    end else if (mem_req.valid) begin
      mem_busy <= 1'b1;
    end else if (mem_rsp.valid) begin
      mem_busy <= 1'b0;
    end
  end

  a_one_outstanding: assert property (
    @(posedge ap_clk) disable iff (areset_m_axi) mem_req.valid |-> !mem_busy
  ) else $error("mem_cmd_engine: new mem_req before previous mem_rsp");

  a_rsp_in_pend: assert property (
    @(posedge ap_clk) disable iff (areset_m_axi)
      mem_rsp.valid |-> (state == STATE_PEND) && mem_busy
  ) else $error("mem_cmd_engine: mem_rsp without an outstanding access");

endmodule

/* cu_buffer.sv */
// Compute-unit request buffer top: register stages, request/response FIFOs, engine, done
module cu_buffer
  import cu_buffer_pkg::*;
#(
  parameter int FIFO_DEPTH  = 32,
  parameter int PROG_THRESH = 16
) (
  input  logic            ap_clk,
  input  logic            areset_m_axi,
  input  cache_request_t  request_in,
  output logic            request_full,
  output cache_response_t response_out,
  input  logic            response_ready,
  output mem_req_t        mem_req,
  input  logic            mem_ready,
  input  mem_rsp_t        mem_rsp,
  output logic            done
);

  // ----------------------------------------------------------------------
  // Internal signals
  // ----------------------------------------------------------------------
  cache_request_t      request_reg;

  // Request FIFO
  cache_req_payload_t  req_dout;
  logic                req_valid;
  logic                req_empty;
  logic                req_prog_full;
  logic                req_pop;

  // Response FIFO
  cache_resp_payload_t resp_din;
  cache_resp_payload_t resp_dout;
  logic                resp_push;
  logic                resp_pop;
  logic                resp_valid;
  logic                resp_empty;
  logic                resp_prog_full;

  logic                engine_idle;
  logic                idle_now;
  logic                idle_q;

  // ----------------------------------------------------------------------
  // Input stage
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      request_reg.valid <= 1'b0;
      request_full      <= 1'b0;
    end else begin
      request_reg.valid <= request_in.valid;
      // Registered prog_full, the slack absorbs pushes already in flight
      request_full      <= req_prog_full;
    end
  end

  always_ff @(posedge ap_clk) begin
    request_reg.payload <= request_in.payload;
  end

  // ----------------------------------------------------------------------
  // Queues and engine
  // ----------------------------------------------------------------------
  sync_fifo #(
    .WIDTH       ($bits(cache_req_payload_t)),
    .DEPTH       (FIFO_DEPTH),
    .PROG_THRESH (PROG_THRESH)
  ) u_req_fifo (
    .ap_clk       (ap_clk),
    .areset_m_axi (areset_m_axi),
    .din          (request_reg.payload),
    .wr_en        (request_reg.valid),
    .rd_en        (req_pop),
    .dout         (req_dout),
    .valid        (req_valid),
    .full         (),
    .empty        (req_empty),
    .prog_full    (req_prog_full)
  );

  mem_cmd_engine u_engine (
    .ap_clk         (ap_clk),
    .areset_m_axi   (areset_m_axi),
    .req_head       (req_dout),
    .req_head_valid (req_valid),
    .req_pop        (req_pop),
    .resp_push      (resp_push),
    .resp_din       (resp_din),
    .resp_prog_full (resp_prog_full),
    .mem_req        (mem_req),
    .mem_ready      (mem_ready),
    .mem_rsp        (mem_rsp),
    .idle           (engine_idle)
  );

  sync_fifo #(
    .WIDTH       ($bits(cache_resp_payload_t)),
    .DEPTH       (FIFO_DEPTH),
    .PROG_THRESH (PROG_THRESH)
  ) u_resp_fifo (
    .ap_clk       (ap_clk),
    .areset_m_axi (areset_m_axi),
    .din          (resp_din),
    .wr_en        (resp_push),
    .rd_en        (resp_pop),
    .dout         (resp_dout),
    .valid        (resp_valid),
    .full         (),
    .empty        (resp_empty),
    .prog_full    (resp_prog_full)
  );

  // ----------------------------------------------------------------------
  // Output stage
  // ----------------------------------------------------------------------
  // Refill the output register when empty or being consumed this cycle
  assign resp_pop = resp_valid && (!response_out.valid || response_ready);

  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      response_out.valid <= 1'b0;
    end else if (resp_pop) begin
      response_out.valid <= 1'b1;
    end else if (response_ready) begin
      response_out.valid <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (resp_pop) begin
      response_out.payload <= resp_dout;
    end
  end

  // ----------------------------------------------------------------------
  // Done flag
  // ----------------------------------------------------------------------
  // Also covers requests and responses held in the register stages
  assign idle_now = req_empty && resp_empty && engine_idle &&
                    !request_reg.valid && !response_out.valid;

  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      idle_q <= 1'b0;
      done   <= 1'b0;
    end else begin
      idle_q <= idle_now;
      done   <= idle_q;
    end
  end

  // Requester contract on the push side
  a_no_push_when_full: assert property (
    @(posedge ap_clk) disable iff (areset_m_axi) request_full |-> !request_in.valid
  ) else $error("cu_buffer: request pushed while request_full is high");

endmodule

/* cu_buffer_checker.sv */
// Testbench checker; watches the cu_buffer ports and compares them with a reference model
module cu_buffer_checker
  import cu_buffer_pkg::*;
#(
  parameter int                MEM_WORDS   = 16,
  parameter logic [DATA_W-1:0] MEM_FILL    = '0,
  parameter int                PROG_THRESH = 16
) (
  input  logic            ap_clk,
  input  logic            areset_m_axi,
  input  cache_request_t  request_in,
  input  logic            request_full,
  input  cache_response_t response_out,
  input  logic            response_ready,
  input  mem_req_t        mem_req,
  input  mem_rsp_t        mem_rsp,
  input  logic            done,
  output int              error_count,
  output int              resp_count
);

  localparam int WORD_W = $clog2(MEM_WORDS);

  // Reference memory stepped in request order
  logic [DATA_W-1:0]   model_mem [MEM_WORDS];
  cache_resp_payload_t exp_rsp_q [$];
  mem_req_t            exp_mem_q [$];
  cache_resp_payload_t exp_rsp;
  mem_req_t            exp_mem;
  logic [WORD_W-1:0]   word;
  logic                outstanding;
  logic                reset_seen;
  // Set once done is high with nothing left to deliver
  logic                done_armed;
  // Requests accepted but not yet sent to memory
  int                  waiting;

  always @(posedge ap_clk) begin
    if (areset_m_axi) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        model_mem[i] = DATA_W'(i) ^ MEM_FILL;
      end
      exp_rsp_q.delete();
      exp_mem_q.delete();
      outstanding = 1'b0;
      reset_seen  = 1'b1;
      done_armed  = 1'b0;
      error_count = 0;
      resp_count  = 0;
    end else begin
      // First cycle out of reset
      if (reset_seen) begin
        reset_seen = 1'b0;
        if (done || response_out.valid || mem_req.valid || request_full) begin
          $display("FAIL t=%0t: outputs not idle after reset (done %b rsp %b mem %b full %b)",
                   $time, done, response_out.valid, mem_req.valid, request_full);
          error_count++;
        end
      end

      // ------------------------------------------------------------------
      // Request-full level against the requests still queued
      // ------------------------------------------------------------------
      // Flag trails the queue by up to two pushes and one pop
      waiting = exp_mem_q.size();
      if (request_full && waiting < PROG_THRESH - 1) begin
        $display("FAIL t=%0t: request_full high with only %0d requests waiting",
                 $time, waiting);
        error_count++;
      end
      if (!request_full && waiting > PROG_THRESH + 1) begin
        $display("FAIL t=%0t: request_full low with %0d requests waiting",
                 $time, waiting);
        error_count++;
      end

      // ------------------------------------------------------------------
      // Expected memory access and response per new request
      // ------------------------------------------------------------------
      if (request_in.valid) begin
        word          = request_in.payload.addr[WORD_W+1:2];
        exp_rsp.cmd   = request_in.payload.cmd;
        exp_rsp.tag   = request_in.payload.tag;
        exp_mem.valid = 1'b1;
        exp_mem.write = (request_in.payload.cmd == CMD_MEM_WRITE);
        exp_mem.addr  = request_in.payload.addr;
        exp_mem.wdata = request_in.payload.wdata;
        if (exp_mem.write) begin
          // Write echoes its data and memory takes only the strobed bytes
          exp_rsp.rdata = request_in.payload.wdata;
          exp_mem.wstrb = request_in.payload.wstrb;
          for (int b = 0; b < STRB_W; b++) begin
            if (request_in.payload.wstrb[b]) begin
              model_mem[word][8*b +: 8] = request_in.payload.wdata[8*b +: 8];
            end
          end
        end else begin
          exp_rsp.rdata = model_mem[word];
          exp_mem.wstrb = '0;
        end
        exp_rsp_q.push_back(exp_rsp);
        exp_mem_q.push_back(exp_mem);
        done_armed = 1'b0;
      end

      // ------------------------------------------------------------------
      // Memory port
      // ------------------------------------------------------------------
      if (mem_rsp.valid) begin
        outstanding = 1'b0;
      end
      if (mem_req.valid) begin
        if (outstanding) begin
          $display("FAIL t=%0t: second mem_req before the previous mem_rsp", $time);
          error_count++;
        end
        if (exp_mem_q.size() == 0) begin
          $display("FAIL t=%0t: mem_req with no request waiting", $time);
          error_count++;
        end else begin
          exp_mem = exp_mem_q.pop_front();
          if (mem_req.write != exp_mem.write || mem_req.addr != exp_mem.addr ||
              mem_req.wstrb != exp_mem.wstrb ||
              (exp_mem.write && mem_req.wdata != exp_mem.wdata)) begin
            $display("FAIL t=%0t: mem_req wr %b addr %h strb %h, expected wr %b addr %h strb %h",
                     $time, mem_req.write, mem_req.addr, mem_req.wstrb,
                     exp_mem.write, exp_mem.addr, exp_mem.wstrb);
            error_count++;
          end
        end
        outstanding = 1'b1;
      end

      // ------------------------------------------------------------------
      // Responses in request order and each exactly once
      // ------------------------------------------------------------------
      if (response_out.valid && response_ready) begin
        if (exp_rsp_q.size() == 0) begin
          $display("FAIL t=%0t: response tag %0d with no request outstanding",
                   $time, response_out.payload.tag);
          error_count++;
        end else begin
          exp_rsp = exp_rsp_q.pop_front();
          if (response_out.payload != exp_rsp) begin
            $display("FAIL t=%0t: response cmd %0d tag %0d data %h, expected %0d %0d %h",
                     $time, response_out.payload.cmd, response_out.payload.tag,
                     response_out.payload.rdata, exp_rsp.cmd, exp_rsp.tag, exp_rsp.rdata);
            error_count++;
          end
        end
        resp_count++;
      end

      // Done holds until the next request
      if (done_armed && !done) begin
        $display("FAIL t=%0t: done dropped with no new request", $time);
        error_count++;
      end
      if (done && exp_rsp_q.size() == 0 && !request_in.valid) begin
        done_armed = 1'b1;
      end
    end
  end

endmodule

/* tb_cu_buffer.sv */
// Testbench top for cu_buffer; drives random traffic, models the memory port, prints the verdict
module tb_cu_buffer
  import cu_buffer_pkg::*;
();

  // ----------------------------------------------------------------------
  // Constants
  // ----------------------------------------------------------------------
  localparam int                CLK_PERIOD    = 100;
  localparam int                FIFO_DEPTH    = 32;
  localparam int                PROG_THRESH   = 16;
  localparam int                MEM_WORDS     = 16;
  localparam int                WORD_W        = $clog2(MEM_WORDS);
  localparam logic [DATA_W-1:0] MEM_FILL      = 32'h5A3C_96E1;
  localparam int                RANDOM_CYCLES = 400;
  localparam int                FILL_TIMEOUT  = 400;
  localparam int                DRAIN_TIMEOUT = 4000;
  localparam int                DONE_TIMEOUT  = 50;
  localparam int                IDLE_HOLD     = 20;
  // Response_ready modes
  localparam int                READY_RANDOM  = 0;
  localparam int                READY_LOW     = 1;
  localparam int                READY_HIGH    = 2;

  logic            ap_clk = 1'b0;
  logic            areset_m_axi;
  cache_request_t  request_in;
  logic            request_full;
  cache_response_t response_out;
  logic            response_ready;
  mem_req_t        mem_req;
  logic            mem_ready = 1'b0;
  mem_rsp_t        mem_rsp = '0;
  logic            done;
  int              error_count;
  int              resp_count;

  // Stimulus state
  logic [31:0]      stim_rng;
  logic [TAG_W-1:0] tag_next;
  int               push_count;
  int               ready_run;
  int               errs_before;
  int               cycles;
  logic             timed_out;

  // Responder streams seeded from multiples of 69
  logic [31:0]       delay_rng = 32'd69 * 2;
  logic [31:0]       ready_rng = 32'd69 * 3;
  logic [DATA_W-1:0] resp_mem [MEM_WORDS];
  logic [DATA_W-1:0] rsp_data = '0;
  logic [WORD_W-1:0] rsp_word;
  // Cycles left before the completion strobe
  int                rsp_wait = 0;

  always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

  cu_buffer #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .PROG_THRESH (PROG_THRESH)
  ) DUT (
    .ap_clk         (ap_clk),
    .areset_m_axi   (areset_m_axi),
    .request_in     (request_in),
    .request_full   (request_full),
    .response_out   (response_out),
    .response_ready (response_ready),
    .mem_req        (mem_req),
    .mem_ready      (mem_ready),
    .mem_rsp        (mem_rsp),
    .done           (done)
  );

  cu_buffer_checker #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_FILL    (MEM_FILL),
    .PROG_THRESH (PROG_THRESH)
  ) u_checker (
    .ap_clk         (ap_clk),
    .areset_m_axi   (areset_m_axi),
    .request_in     (request_in),
    .request_full   (request_full),
    .response_out   (response_out),
    .response_ready (response_ready),
    .mem_req        (mem_req),
    .mem_rsp        (mem_rsp),
    .done           (done),
    .error_count    (error_count),
    .resp_count     (resp_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ----------------------------------------------------------------------
  // Memory responder
  // ----------------------------------------------------------------------
  // Accesses sampled on the rising edge with one in flight at a time
  always @(posedge ap_clk) begin
    if (areset_m_axi) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        resp_mem[i] = DATA_W'(i) ^ MEM_FILL;
      end
      rsp_wait = 0;
    end else if (mem_req.valid) begin
      rsp_word = mem_req.addr[WORD_W+1:2];
      if (mem_req.write) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (mem_req.wstrb[b]) begin
            resp_mem[rsp_word][8*b +: 8] = mem_req.wdata[8*b +: 8];
          end
        end
      end
      rsp_data  = resp_mem[rsp_word];
      delay_rng = xorshift32(delay_rng);
      rsp_wait  = 1 + int'(delay_rng % 6);
    end else if (rsp_wait > 0) begin
      rsp_wait = rsp_wait - 1;
    end
  end

  always @(negedge ap_clk) begin
    ready_rng     = xorshift32(ready_rng);
    // Port stalled about one cycle in four
    mem_ready     = (ready_rng[1:0] != 2'b00);
    mem_rsp.valid = (rsp_wait == 1);
    mem_rsp.rdata = rsp_data;
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  task automatic drive_cycle(input logic try_push, input int ready_mode);
    logic [31:0] pick;
    logic [31:0] data;
    @(negedge ap_clk);
    stim_rng   = xorshift32(stim_rng);
    pick       = stim_rng;
    stim_rng   = xorshift32(stim_rng);
    data       = stim_rng;
    request_in = '0;
    // About half the cycles carry a request while there is room
    if (try_push && pick[0] && !request_full) begin
      request_in.valid         = 1'b1;
      request_in.payload.cmd   = pick[1] ? CMD_MEM_WRITE : CMD_MEM_READ;
      request_in.payload.tag   = tag_next;
      request_in.payload.addr  = ADDR_W'({pick[WORD_W+1:2], 2'b00});
      request_in.payload.wdata = data;
      request_in.payload.wstrb = pick[11:8];
      tag_next   = tag_next + 1'b1;
      push_count = push_count + 1;
    end
    case (ready_mode)
      READY_LOW:  response_ready = 1'b0;
      READY_HIGH: response_ready = 1'b1;
      default: begin
        if (ready_run > 0) begin
          ready_run = ready_run - 1;
        end else begin
          response_ready = ~response_ready;
          // Low stretches run much longer than high ones
          ready_run = response_ready ? int'(pick[14:12]) : int'(pick[20:16]) + 8;
        end
      end
    endcase
  endtask

  task automatic report_test(input string name);
    if (error_count == errs_before) begin
      $display("Test %s ok", name);
    end else begin
      $display("Test %s had %0d errors", name, error_count - errs_before);
    end
    errs_before = error_count;
  endtask

  initial begin
    areset_m_axi   = 1'b1;
    request_in     = '0;
    response_ready = 1'b0;
    stim_rng       = 32'd69;
    tag_next       = '0;
    push_count     = 0;
    ready_run      = 0;
    errs_before    = 0;
    timed_out      = 1'b0;
    repeat (8) @(posedge ap_clk);
    @(negedge ap_clk);
    areset_m_axi = 1'b0;

    // Outputs checked on the first cycle out of reset
    repeat (4) drive_cycle(1'b0, READY_HIGH);
    report_test("reset_state");

    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      drive_cycle(1'b1, READY_RANDOM);
    end
    report_test("random_traffic");

    // Hold responses back until the request side fills up
    cycles = 0;
    while (!request_full && cycles < FILL_TIMEOUT) begin
      drive_cycle(1'b1, READY_LOW);
      cycles++;
    end
    if (!request_full) begin
      $display("Timeout: request_full did not rise within %0d cycles", FILL_TIMEOUT);
      timed_out = 1'b1;
    end
    repeat (20) drive_cycle(1'b1, READY_LOW);
    report_test("backpressure");

    // Drain everything and wait for done to rise and hold
    cycles = 0;
    while (resp_count != push_count && cycles < DRAIN_TIMEOUT) begin
      drive_cycle(1'b0, READY_HIGH);
      cycles++;
    end
    if (resp_count != push_count) begin
      $display("Timeout: only %0d of %0d responses arrived", resp_count, push_count);
      timed_out = 1'b1;
    end
    cycles = 0;
    while (!done && cycles < DONE_TIMEOUT) begin
      drive_cycle(1'b0, READY_HIGH);
      cycles++;
    end
    if (!done) begin
      $display("Timeout: done did not rise within %0d cycles of draining", DONE_TIMEOUT);
      timed_out = 1'b1;
    end
    repeat (IDLE_HOLD) drive_cycle(1'b0, READY_HIGH);
    report_test("drain_done");

    $display("Totals: %0d requests, %0d responses checked, %0d errors",
             push_count, resp_count, error_count);
    if (timed_out || error_count != 0) begin
      $display("Simulation FAILED");
    end else begin
      $display("Simulation PASSED");
    end
    $finish;
  end

endmodule

/* cu_buffer.f */
cu_buffer_pkg.sv
sync_fifo.sv
mem_cmd_engine.sv
cu_buffer.sv
cu_buffer_checker.sv
tb_cu_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cu_buffer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=sim_cu_buffer

verilator --binary --timing --assert -j 0 \
  --top-module tb_cu_buffer \
  -f cu_buffer.f \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi

exit 0
